/* omegaNetPkg.sv */
// Omega network definitions
`default_nettype none

package omegaNetPkg;

  // Number of network inputs, equal to the number of outputs.
  // It must stay a power of two for the shuffle wiring to close.
  localparam int unsigned NumPorts = 8;

  // One routing level per destination bit, most significant bit first.
  localparam int unsigned NumLevels = $clog2(NumPorts);

  // Every level is built from 2x2 switches.
  localparam int unsigned NumSwitches = NumPorts / 2;

  // Width of the user payload carried on each stream.
  localparam int unsigned DataWidth = 16;

  // Width of a port number, used for the destination and the source index.
  localparam int unsigned PortIdxWidth = NumLevels;

  // Payload word of a stream.
  typedef logic [DataWidth-1:0] payloadT;

  // Port number. The same encoding serves as the output select at an input
  // and as the source index at an output.
  typedef logic [PortIdxWidth-1:0] portIdxT;

endpackage

`default_nettype wire

/* rrArbiter.sv */
// Two-way round-robin arbiter
`default_nettype none

module rrArbiter (
  input  logic       clk_i,
  input  logic       rstN_i,
  input  logic [1:0] req_i,
  input  logic       accept_i,
  output logic [1:0] grant_o,
  output logic       valid_o
);

  // Requester that wins a tie on the next free arbitration.
  logic prioPtr;
  // Set while a grant was offered but not yet accepted.
  logic lockActive;
  logic lockIdx;
  // Winner of an unlocked arbitration.
  logic freeIdx;
  // Requester that is granted in this cycle.
  logic winIdx;

  // The preferred requester wins if it requests, otherwise the other one.
  assign freeIdx = req_i[prioPtr] ? prioPtr : ~prioPtr;

  // A pending grant is held until its transfer completes.
  // This keeps the selected payload stable at the switch output register.
  assign winIdx  = lockActive ? lockIdx : freeIdx;
  assign valid_o = lockActive ? req_i[lockIdx] : |req_i;

  assign grant_o[0] = valid_o & ~winIdx;
  assign grant_o[1] = valid_o & winIdx;

  always_ff @(posedge clk_i) begin
    if (!rstN_i) begin
      prioPtr    <= 1'b0;
      lockActive <= 1'b0;
      lockIdx    <= 1'b0;
    end else if (valid_o && accept_i) begin
      // The winner moves to the back of the line.
      prioPtr    <= ~winIdx;
      lockActive <= 1'b0;
    end else if (valid_o) begin
      // Offered but not taken, so freeze the decision.
      lockActive <= 1'b1;
      lockIdx    <= winIdx;
    end else begin
      lockActive <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* outRegister.sv */
// Two-entry output skid buffer
`default_nettype none

module outRegister (
  input  logic                 clk_i,
  input  logic                 rstN_i,
  input  logic                 valid_i,
  input  omegaNetPkg::payloadT payload_i,
  input  omegaNetPkg::portIdxT dest_i,
  input  omegaNetPkg::portIdxT srcIdx_i,
  output logic                 ready_o,
  output logic                 valid_o,
  output omegaNetPkg::payloadT payload_o,
  output omegaNetPkg::portIdxT dest_o,
  output omegaNetPkg::portIdxT srcIdx_o,
  input  logic                 ready_i
);
  import omegaNetPkg::*;

  // The main entry drives the output, the spare entry catches the word
  // that arrives while the main entry is stalled.
  logic    mainValid;
  payloadT mainPayload;
  portIdxT mainDest;
  portIdxT mainSrcIdx;
  logic    spareValid;
  payloadT sparePayload;
  portIdxT spareDest;
  portIdxT spareSrcIdx;

  logic inFire;
  logic mainFree;

  // In-ready comes straight from a flop, so no ready path runs through here.
  assign ready_o  = ~spareValid;
  assign inFire   = valid_i & ready_o;
  // The main entry can load when it is empty or leaves in this cycle.
  assign mainFree = ~mainValid | ready_i;

  always_ff @(posedge clk_i) begin
    if (!rstN_i) begin
      mainValid  <= 1'b0;
      spareValid <= 1'b0;
    end else if (mainFree) begin
      // The spare holds the older word and always goes first.
      mainValid  <= spareValid | inFire;
      spareValid <= 1'b0;
    end else if (inFire) begin
      spareValid <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (mainFree && spareValid) begin
      mainPayload <= sparePayload;
      mainDest    <= spareDest;
      mainSrcIdx  <= spareSrcIdx;
    end else if (mainFree && inFire) begin
      mainPayload <= payload_i;
      mainDest    <= dest_i;
      mainSrcIdx  <= srcIdx_i;
    end
    if (!mainFree && inFire) begin
      sparePayload <= payload_i;
      spareDest    <= dest_i;
      spareSrcIdx  <= srcIdx_i;
    end
  end

  assign valid_o   = mainValid;
  assign payload_o = mainPayload;
  assign dest_o    = mainDest;
  assign srcIdx_o  = mainSrcIdx;

endmodule

`default_nettype wire

/* streamSwitch.sv */
// 2x2 stream switch
`default_nettype none

module streamSwitch (
  input  logic                       clk_i,
  input  logic                       rstN_i,
  input  logic                 [1:0] destBit_i,
  input  logic                 [1:0] inValid_i,
  input  omegaNetPkg::payloadT [1:0] inPayload_i,
  input  omegaNetPkg::portIdxT [1:0] inDest_i,
  input  omegaNetPkg::portIdxT [1:0] inSrcIdx_i,
  output logic                 [1:0] inReady_o,
  output logic                 [1:0] outValid_o,
  output omegaNetPkg::payloadT [1:0] outPayload_o,
  output omegaNetPkg::portIdxT [1:0] outDest_o,
  output omegaNetPkg::portIdxT [1:0] outSrcIdx_o,
  input  logic                 [1:0] outReady_i
);
  import omegaNetPkg::*;

  // Requests, indexed as [output][input].
  logic [1:0][1:0] reqMatrix;
  // Grants, indexed as [output][input].
  logic [1:0][1:0] grantMatrix;
  // Arbiter result and register ready per output.
  logic [1:0] arbValid;
  logic [1:0] regReady;
  // Word selected by each output's arbiter.
  payloadT [1:0] muxPayload;
  portIdxT [1:0] muxDest;
  portIdxT [1:0] muxSrcIdx;

  // Decode: the destination bit of the level picks output 0 or output 1.
  for (genvar inIdx = 0; inIdx < 2; inIdx++) begin : genDecode
    assign reqMatrix[0][inIdx] = inValid_i[inIdx] & ~destBit_i[inIdx];
    assign reqMatrix[1][inIdx] = inValid_i[inIdx] & destBit_i[inIdx];

    // An input moves when its requested output grants it and can take a word.
    // An output that nobody requests shows its register's ready to both inputs.
    assign inReady_o[inIdx] = regReady[destBit_i[inIdx]] &
                              (grantMatrix[destBit_i[inIdx]][inIdx] |
                               ~arbValid[destBit_i[inIdx]]);
  end

  for (genvar outIdx = 0; outIdx < 2; outIdx++) begin : genOutputs
    logic grantSel;

    rrArbiter u_rrArbiter (
      .clk_i    (clk_i),
      .rstN_i   (rstN_i),
      .req_i    (reqMatrix[outIdx]),
      .accept_i (regReady[outIdx]),
      .grant_o  (grantMatrix[outIdx]),
      .valid_o  (arbValid[outIdx])
    );

    // The grant is one-hot, so its upper bit names the selected input.
    assign grantSel = grantMatrix[outIdx][1];

    assign muxPayload[outIdx] = inPayload_i[grantSel];
    assign muxDest[outIdx]    = inDest_i[grantSel];
    assign muxSrcIdx[outIdx]  = inSrcIdx_i[grantSel];

    // The register takes the winner on the same edge as the input handshake.
    outRegister u_outRegister (
      .clk_i     (clk_i),
      .rstN_i    (rstN_i),
      .valid_i   (arbValid[outIdx]),
      .payload_i (muxPayload[outIdx]),
      .dest_i    (muxDest[outIdx]),
      .srcIdx_i  (muxSrcIdx[outIdx]),
      .ready_o   (regReady[outIdx]),
      .valid_o   (outValid_o[outIdx]),
      .payload_o (outPayload_o[outIdx]),
      .dest_o    (outDest_o[outIdx]),
      .srcIdx_o  (outSrcIdx_o[outIdx]),
      .ready_i   (outReady_i[outIdx])
    );
  end

endmodule

`default_nettype wire

/* omegaStage.sv */
// One routing level of the omega network
`default_nettype none

module omegaStage #(
  parameter int unsigned Level = 0
) (
  input  logic                                          clk_i,
  input  logic                                          rstN_i,
  input  logic                 [omegaNetPkg::NumPorts-1:0] inValid_i,
  input  omegaNetPkg::payloadT [omegaNetPkg::NumPorts-1:0] inPayload_i,
  input  omegaNetPkg::portIdxT [omegaNetPkg::NumPorts-1:0] inDest_i,
  input  omegaNetPkg::portIdxT [omegaNetPkg::NumPorts-1:0] inSrcIdx_i,
  output logic                 [omegaNetPkg::NumPorts-1:0] inReady_o,
  output logic                 [omegaNetPkg::NumPorts-1:0] outValid_o,
  output omegaNetPkg::payloadT [omegaNetPkg::NumPorts-1:0] outPayload_o,
  output omegaNetPkg::portIdxT [omegaNetPkg::NumPorts-1:0] outDest_o,
  output omegaNetPkg::portIdxT [omegaNetPkg::NumPorts-1:0] outSrcIdx_o,
  input  logic                 [omegaNetPkg::NumPorts-1:0] outReady_i
);
  import omegaNetPkg::*;

  // Level 0 routes on the most significant destination bit.
  localparam int unsigned BitSel = NumLevels - 1 - Level;

  // Destination bit that steers each lane in this level.
  logic [NumPorts-1:0] laneDestBit;

  for (genvar lane = 0; lane < NumPorts; lane++) begin : genDestBit
    assign laneDestBit[lane] = inDest_i[lane][BitSel];
  end

  // Switch j serves lanes 2j and 2j+1 on both sides.
  for (genvar sw = 0; sw < NumSwitches; sw++) begin : genSwitches
    streamSwitch u_streamSwitch (
      .clk_i        (clk_i),
      .rstN_i       (rstN_i),
      .destBit_i    (laneDestBit[2*sw +: 2]),
      .inValid_i    (inValid_i[2*sw +: 2]),
      .inPayload_i  (inPayload_i[2*sw +: 2]),
      .inDest_i     (inDest_i[2*sw +: 2]),
      .inSrcIdx_i   (inSrcIdx_i[2*sw +: 2]),
      .inReady_o    (inReady_o[2*sw +: 2]),
      .outValid_o   (outValid_o[2*sw +: 2]),
      .outPayload_o (outPayload_o[2*sw +: 2]),
      .outDest_o    (outDest_o[2*sw +: 2]),
      .outSrcIdx_o  (outSrcIdx_o[2*sw +: 2]),
      .outReady_i   (outReady_i[2*sw +: 2])
    );
  end

endmodule

`default_nettype wire

/* omegaNet.sv */
// 8x8 omega network for valid/ready streams
`default_nettype none

module omegaNet (
  input  logic                                          clk_i,
  input  logic                                          rstN_i,
  input  logic                 [omegaNetPkg::NumPorts-1:0] valid_i,
  input  omegaNetPkg::payloadT [omegaNetPkg::NumPorts-1:0] data_i,
  input  omegaNetPkg::portIdxT [omegaNetPkg::NumPorts-1:0] sel_i,
  output logic                 [omegaNetPkg::NumPorts-1:0] ready_o,
  output logic                 [omegaNetPkg::NumPorts-1:0] valid_o,
  output omegaNetPkg::payloadT [omegaNetPkg::NumPorts-1:0] data_o,
  output omegaNetPkg::portIdxT [omegaNetPkg::NumPorts-1:0] idx_o,
  input  logic                 [omegaNetPkg::NumPorts-1:0] ready_i
);
  import omegaNetPkg::*;

  // Lane signals on both sides of every level, indexed as [level][lane].
  logic    [NumLevels-1:0][NumPorts-1:0] stInValid;
  logic    [NumLevels-1:0][NumPorts-1:0] stInReady;
  payloadT [NumLevels-1:0][NumPorts-1:0] stInPayload;
  portIdxT [NumLevels-1:0][NumPorts-1:0] stInDest;
  portIdxT [NumLevels-1:0][NumPorts-1:0] stInSrcIdx;
  logic    [NumLevels-1:0][NumPorts-1:0] stOutValid;
  logic    [NumLevels-1:0][NumPorts-1:0] stOutReady;
  payloadT [NumLevels-1:0][NumPorts-1:0] stOutPayload;
  portIdxT [NumLevels-1:0][NumPorts-1:0] stOutDest;
  portIdxT [NumLevels-1:0][NumPorts-1:0] stOutSrcIdx;

  // Input port p enters lane NumPorts-1-p and is tagged with its own number.
  for (genvar p = 0; p < NumPorts; p++) begin : genInputs
    assign stInValid[0][NumPorts-1-p]   = valid_i[p];
    assign stInPayload[0][NumPorts-1-p] = data_i[p];
    assign stInDest[0][NumPorts-1-p]    = sel_i[p];
    assign stInSrcIdx[0][NumPorts-1-p]  = portIdxT'(p);
    assign ready_o[p]                   = stInReady[0][NumPorts-1-p];
  end

  for (genvar lvl = 0; lvl < NumLevels; lvl++) begin : genLevels
    omegaStage #(
      .Level (lvl)
    ) u_omegaStage (
      .clk_i        (clk_i),
      .rstN_i       (rstN_i),
      .inValid_i    (stInValid[lvl]),
      .inPayload_i  (stInPayload[lvl]),
      .inDest_i     (stInDest[lvl]),
      .inSrcIdx_i   (stInSrcIdx[lvl]),
      .inReady_o    (stInReady[lvl]),
      .outValid_o   (stOutValid[lvl]),
      .outPayload_o (stOutPayload[lvl]),
      .outDest_o    (stOutDest[lvl]),
      .outSrcIdx_o  (stOutSrcIdx[lvl]),
      .outReady_i   (stOutReady[lvl])
    );
  end

  // Perfect shuffle: switch L/2 port L%2 feeds switch L%4 port L/4.
  // The next level lane is therefore 2*(L%4) + L/4.
  for (genvar lvl = 0; lvl < NumLevels - 1; lvl++) begin : genShuffles
    for (genvar lane = 0; lane < NumPorts; lane++) begin : genLanes
      localparam int unsigned NextLane = 2 * (lane % NumSwitches) + lane / NumSwitches;

      assign stInValid[lvl+1][NextLane]   = stOutValid[lvl][lane];
      assign stInPayload[lvl+1][NextLane] = stOutPayload[lvl][lane];
      assign stInDest[lvl+1][NextLane]    = stOutDest[lvl][lane];
      assign stInSrcIdx[lvl+1][NextLane]  = stOutSrcIdx[lvl][lane];
      assign stOutReady[lvl][lane]        = stInReady[lvl+1][NextLane];
    end
  end

  // Output q is lane q of the last level.
  // The destination has been fully consumed there and only the payload and
  // the source index leave the network.
  for (genvar q = 0; q < NumPorts; q++) begin : genOutputs
    assign valid_o[q]                 = stOutValid[NumLevels-1][q];
    assign data_o[q]                  = stOutPayload[NumLevels-1][q];
    assign idx_o[q]                   = stOutSrcIdx[NumLevels-1][q];
    assign stOutReady[NumLevels-1][q] = ready_i[q];
  end

endmodule

`default_nettype wire

/* omegaNetTb.sv */
// Omega network testbench
`default_nettype none

module omegaNetTb;
  import omegaNetPkg::*;

  // Packet counts of the test phases.
  localparam int SinglePackets = NumPorts * NumPorts;
  localparam int HotPerInput   = 8;
  localparam int RandomPackets = 2000;
  localparam int TotalPackets  = SinglePackets + NumPorts * HotPerInput + RandomPackets;
  // Each packet gets a generous budget on top of a fixed start-up margin.
  localparam int TimeoutCycles = 16 * TotalPackets + 200;
  // Cycles from an input handshake to the output handshake on an idle network.
  localparam int IdleLatency   = 3;

  logic                clk;
  logic                rstN;
  logic [NumPorts-1:0] validI;
  payloadT [NumPorts-1:0] dataI;
  portIdxT [NumPorts-1:0] selI;
  logic [NumPorts-1:0] readyO;
  logic [NumPorts-1:0] validO;
  payloadT [NumPorts-1:0] dataO;
  portIdxT [NumPorts-1:0] idxO;
  logic [NumPorts-1:0] readyI;

  integer seed = 32'hf4bd_6ac2;

  // Packets waiting at each input, in send order.
  payloadT txData [NumPorts][$];
  portIdxT txDest [NumPorts][$];
  // Expected payloads and send cycles, indexed as [output][source].
  payloadT expQ [NumPorts][NumPorts][$];
  int      sendCycQ [NumPorts][NumPorts][$];
  // Every payload is unique, so it names the input that sent it.
  portIdxT srcOfPayload [2**DataWidth];

  logic [NumPorts-1:0] inFired;
  logic [NumPorts-1:0] holdPending;
  payloadT [NumPorts-1:0] holdData;
  portIdxT [NumPorts-1:0] holdIdx;
  logic latencyCheck;
  logic backPressure;
  int   cycleCount;
  int   outstanding;
  int   sentCount;
  int   receivedCount;
  int   nextSeq;

  omegaNet u_omegaNet (
    .clk_i   (clk),
    .rstN_i  (rstN),
    .valid_i (validI),
    .data_i  (dataI),
    .sel_i   (selI),
    .ready_o (readyO),
    .valid_o (validO),
    .data_o  (dataO),
    .idx_o   (idxO),
    .ready_i (readyI)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // An omega network with one path per pair delivers each packet to the
  // output named by its destination, whatever input it came from.
  function automatic portIdxT refRoute(portIdxT dest, portIdxT src);
    return dest;
  endfunction

  // An odd multiplier makes this a bijection of the sequence number.
  function automatic payloadT scramblePayload(int seq);
    return payloadT'(seq * 16'h9e37 + 16'h35c1);
  endfunction

  task automatic stopWithFailure();
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic checkPayload(string name, payloadT got, payloadT exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      stopWithFailure();
    end
  endtask

  task automatic checkIdx(string name, portIdxT got, portIdxT exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
      stopWithFailure();
    end
  endtask

  task automatic checkBit(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
      stopWithFailure();
    end
  endtask

  task automatic checkCycles(string name, int got, int exp);
    if (got != exp) begin
      $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
      stopWithFailure();
    end
  endtask

  // Called right after a rising edge, so the drivers see it on the next falling edge.
  task automatic queuePacket(portIdxT src, portIdxT dest);
    payloadT word;
    word = scramblePayload(nextSeq);
    nextSeq++;
    srcOfPayload[word] = src;
    txData[src].push_back(word);
    txDest[src].push_back(dest);
    outstanding++;
    sentCount++;
  endtask

  // Returns on a rising edge once every queued packet has left the network.
  task automatic waitIdle();
    @(negedge clk);
    while (outstanding != 0) begin
      @(negedge clk);
    end
    @(posedge clk);
  endtask

  // Input drivers hold a word until its handshake, then offer the next one.
  always @(negedge clk) begin
    integer rnd;
    if (rstN) begin
      for (int p = 0; p < NumPorts; p++) begin
        if (inFired[p] || !validI[p]) begin
          if (txData[p].size() > 0) begin
            validI[p] <= 1'b1;
            dataI[p]  <= txData[p].pop_front();
            selI[p]   <= txDest[p].pop_front();
          end else begin
            validI[p] <= 1'b0;
          end
          inFired[p] = 1'b0;
        end
      end
      // Outputs stall on about one cycle in four under back-pressure.
      for (int q = 0; q < NumPorts; q++) begin
        rnd = $random(seed);
        readyI[q] <= backPressure ? (rnd[1:0] != 2'b00) : 1'b1;
      end
    end
  end

  // Scoreboard: records input handshakes and compares output handshakes.
  always @(posedge clk) begin
    portIdxT src;
    int      sent;
    if (rstN) begin
      for (int p = 0; p < NumPorts; p++) begin
        if (validI[p] && readyO[p]) begin
          expQ[refRoute(selI[p], portIdxT'(p))][p].push_back(dataI[p]);
          sendCycQ[refRoute(selI[p], portIdxT'(p))][p].push_back(cycleCount);
          inFired[p] = 1'b1;
        end
      end
      for (int q = 0; q < NumPorts; q++) begin
        // A stalled output must keep its word until it is taken.
        if (holdPending[q]) begin
          checkBit($sformatf("valid_o[%0d]", q), validO[q], 1'b1);
          checkPayload($sformatf("data_o[%0d]", q), dataO[q], holdData[q]);
          checkIdx($sformatf("idx_o[%0d]", q), idxO[q], holdIdx[q]);
        end
        holdPending[q] = validO[q] && !readyI[q];
        holdData[q]    = dataO[q];
        holdIdx[q]     = idxO[q];
        if (validO[q] && readyI[q]) begin
          src = srcOfPayload[dataO[q]];
          checkIdx($sformatf("idx_o[%0d]", q), idxO[q], src);
          if (expQ[q][src].size() == 0) begin
            $display("output %0d delivered a packet from input %0d that was not expected at %0t",
                     q, src, $time);
            stopWithFailure();
          end
          // Popping the head checks the per-source order.
          checkPayload($sformatf("data_o[%0d]", q), dataO[q], expQ[q][src].pop_front());
          sent = sendCycQ[q][src].pop_front();
          if (latencyCheck) begin
            checkCycles($sformatf("latency to output %0d", q), cycleCount - sent, IdleLatency);
          end
          outstanding--;
          receivedCount++;
        end
      end
    end
    cycleCount++;
    if (cycleCount > TimeoutCycles) begin
      $display("timeout: the run did not finish within %0d cycles", TimeoutCycles);
      stopWithFailure();
    end
  end

  initial begin
    integer rnd;
    portIdxT hotDest;
    int leftover;
    rstN          = 1'b0;
    validI        = '0;
    dataI         = '0;
    selI          = '0;
    readyI        = '1;
    inFired       = '0;
    holdPending   = '0;
    holdData      = '0;
    holdIdx       = '0;
    latencyCheck  = 1'b0;
    backPressure  = 1'b0;
    cycleCount    = 0;
    outstanding   = 0;
    sentCount     = 0;
    receivedCount = 0;
    nextSeq       = 0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;

    // Nothing may come out of an empty network, and every input takes a word.
    repeat (2) @(negedge clk);
    for (int q = 0; q < NumPorts; q++) begin
      checkBit($sformatf("valid_o[%0d]", q), validO[q], 1'b0);
    end
    for (int p = 0; p < NumPorts; p++) begin
      checkBit($sformatf("ready_o[%0d]", p), readyO[p], 1'b1);
    end
    @(posedge clk);

    // Every source and destination pair, one packet at a time.
    latencyCheck = 1'b1;
    for (int s = 0; s < NumPorts; s++) begin
      for (int d = 0; d < NumPorts; d++) begin
        queuePacket(portIdxT'(s), portIdxT'(d));
        waitIdle();
      end
    end
    latencyCheck = 1'b0;

    // All inputs aim at one output at once.
    rnd = $random(seed);
    hotDest = portIdxT'(rnd);
    for (int n = 0; n < HotPerInput; n++) begin
      for (int s = 0; s < NumPorts; s++) begin
        queuePacket(portIdxT'(s), hotDest);
      end
    end
    waitIdle();

    // Random traffic, first with free outputs and then with random stalls.
    for (int n = 0; n < RandomPackets; n++) begin
      if (n == RandomPackets / 2) begin
        waitIdle();
        backPressure = 1'b1;
      end
      rnd = $random(seed);
      queuePacket(portIdxT'(rnd[2:0]), portIdxT'(rnd[6:4]));
    end
    waitIdle();
    backPressure = 1'b0;
    repeat (4) @(posedge clk);

    // Every expected packet must have been taken off its queue.
    leftover = 0;
    for (int q = 0; q < NumPorts; q++) begin
      for (int s = 0; s < NumPorts; s++) begin
        leftover += expQ[q][s].size();
      end
    end

    if (leftover == 0 && receivedCount == sentCount) begin
      $display("NO ERRORS");
      $finish;
    end else begin
      $display("%0d packets still expected, %0d received of %0d sent",
               leftover, receivedCount, sentCount);
      $display("ERRORS FOUND");
      $fatal(1);
    end
  end

endmodule

`default_nettype wire

/* omegaNet.f */
omegaNetPkg.sv
rrArbiter.sv
outRegister.sv
streamSwitch.sv
omegaStage.sv
omegaNet.sv
omegaNetTb.sv

/* Bender.yml */
package:
  name: omegaNet

sources:
  # Package first, then the design from the leaves up to the top level.
  - omegaNetPkg.sv
  - rrArbiter.sv
  - outRegister.sv
  - streamSwitch.sv
  - omegaStage.sv
  - omegaNet.sv

  # Testbench, only for simulation.
  - target: simulation
    files:
      - omegaNetTb.sv
